// ==== src.f ====
common/obj_pkg.sv
src/obj_timer.sv
obj/obj_dma.sv
obj/obj_scan_fsm.sv
obj/obj_draw.sv
obj/obj_line_buf.sv
src/obj_top.sv
test/obj_tb.sv

// ==== Makefile ====
# Verilator build and run for the sprite engine testbench

VERILATOR ?= verilator
TOP       ?= obj_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= Everything OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== test/obj_golden.txt ====
# T entry byte0 byte1 byte2 byte3 (hex)  sprite table entry, byte3 = ypos
# W frame vrender hdump addr data (hex)  VRAM write,  P frame vrender hdump pxl (hex)  check
T 0 0a 04 0a 04
T 1 0c 48 1e 04
T 2 0e 2c 32 04
T 3 10 10 46 04
T 4 12 14 48 04
T 5 14 18 64 04
P 1 3 20 00
P 1 4 143 43
P 1 4 144 44
P 1 4 145 51
P 1 4 150 56
P 1 6 19 00
P 1 6 20 14
P 1 6 29 16
P 1 6 35 1c
P 1 6 36 00
P 1 6 60 2c
P 1 6 65 27
P 1 6 75 24
P 1 6 100 3a
P 1 6 110 3d
P 1 6 200 64
W 1 10 0 15 1c
P 1 11 153 44
P 1 12 201 61
P 1 12 319 00
P 1 19 23 11
P 1 19 100 00
P 1 19 101 31
P 1 20 20 00
P 1 39 319 00
P 2 6 200 74
P 2 12 201 71

// ==== test/obj_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the sprite engine
// VRAM and ROM models around obj_top, table bytes,
// VRAM writes and pixel checks from the golden file
// run from the project root so the file is found
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module obj_tb
    import obj_pkg::*;
;

    localparam int H_TOTAL   = 320;
    localparam int H_VIS     = 256;
    localparam int V_TOTAL   = 40;
    localparam int V_VIS     = 32;
    localparam int OBJ_COUNT = 16;
    localparam int FRAME     = H_TOTAL * V_TOTAL;
    // checks end inside frame 2 so three frames plus two lines is plenty
    localparam int WATCH_CYCLES = 3 * FRAME + 2 * H_TOTAL;

    logic             clk = 1'b0;
    logic             rst = 1'b1;
    logic [9:0]       vram_addr;
    logic [7:0]       vram_data = 8'd0;
    rom_addr_t        rom_addr;
    logic             rom_cs;
    logic [31:0]      rom_data = 32'd0;
    logic             rom_ok = 1'b0;
    logic [8:0]       hdump;
    logic [8:0]       vrender;
    logic [PXL_W-1:0] pxl;

    logic [7:0]       vram [1024];
    logic [9:0]       vram_q = 10'd0;
    integer           seed = 32'hd732_0818;
    logic             rom_busy = 1'b0;
    int               rom_wait = 0;
    rom_addr_t        rom_held;
    int               n = 0;

    // timed events from the golden file in file order
    int               ev_pos [$];
    byte              ev_kind [$];
    logic [8:0]       ev_h [$];
    logic [8:0]       ev_v [$];
    logic [9:0]       ev_addr [$];
    logic [7:0]       ev_data [$];
    logic [PXL_W-1:0] ev_px [$];

    obj_top #(
        .H_TOTAL   (H_TOTAL),
        .H_VIS     (H_VIS),
        .V_TOTAL   (V_TOTAL),
        .V_VIS     (V_VIS),
        .OBJ_COUNT (OBJ_COUNT)
    ) uut (
        .clk       (clk),
        .rst       (rst),
        .vram_addr (vram_addr),
        .vram_data (vram_data),
        .rom_addr  (rom_addr),
        .rom_cs    (rom_cs),
        .rom_data  (rom_data),
        .rom_ok    (rom_ok),
        .hdump     (hdump),
        .vrender   (vrender),
        .pxl       (pxl)
    );

    always #5 clk = ~clk;

    task automatic report_fail(input string msg);
        $display("%s", msg);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_pxl(input logic [PXL_W-1:0] exp);
        if (pxl !== exp) begin
            report_fail($sformatf("Error at %0t: pxl expected %02h, got %02h", $time, exp, pxl));
        end
    endtask

    task automatic check_timer(input logic [8:0] exp_h, input logic [8:0] exp_v);
        if (hdump !== exp_h) begin
            report_fail($sformatf("Error at %0t: hdump expected %0d, got %0d",
                $time, exp_h, hdump));
        end else if (vrender !== exp_v) begin
            report_fail($sformatf("Error at %0t: vrender expected %0d, got %0d",
                $time, exp_v, vrender));
        end
    endtask

    // address must hold while the request waits
    task automatic check_rom_addr(input rom_addr_t exp);
        if (rom_addr !== exp) begin
            report_fail($sformatf("Error at %0t: rom_addr expected %04h, got %04h",
                $time, exp, rom_addr));
        end
    endtask

    // nibble k of word a is the low four bits of a + k
    function automatic logic [31:0] rom_word(input rom_addr_t a);
        logic [31:0] w;
        logic [13:0] s;
        for (int k = 0; k < 8; k++) begin
            s = 14'(a) + 14'(k);
            w[k*4 +: 4] = s[3:0];
        end
        return w;
    endfunction

    // VRAM data one clock after the address
    always @(negedge clk) begin
        vram_data <= vram[vram_q];
        vram_q    <= vram_addr;
    end

    // ROM answers 0 to 3 clocks after cs with one pulse of ok
    always @(negedge clk) begin
        if (rst || !rom_cs || rom_ok) begin
            rom_ok   <= 1'b0;
            rom_busy = 1'b0;
        end else begin
            if (!rom_busy) begin
                rom_busy = 1'b1;
                rom_wait = $random(seed) & 3;
                rom_held = rom_addr;
            end else begin
                check_rom_addr(rom_held);
            end
            if (rom_wait == 0) begin
                rom_ok   <= 1'b1;
                rom_data <= rom_word(rom_addr);
                rom_busy = 1'b0;
            end else begin
                rom_wait = rom_wait - 1;
            end
        end
    end

    task automatic load_golden();
        int    fd;
        int    rc;
        int    want;
        int    e;
        int    f;
        int    v;
        int    h;
        int    a;
        int    d;
        int    b [4];
        byte   kind;
        string line;
        // unused table entries get ypos of 128 or more and never hit
        for (int i = 0; i < 1024; i++) begin
            vram[i] = 8'h80 | (8'(i) ^ 8'(i >> 8));
        end
        fd = $fopen("test/obj_golden.txt", "r");
        if (fd == 0) begin
            report_fail("cannot open the golden file test/obj_golden.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                kind = (line.len() < 2) ? "#" : line[0];
                if (kind == "T") begin
                    rc = $sscanf(line, "T %d %h %h %h %h", e, b[0], b[1], b[2], b[3]);
                    if (rc != 5) begin
                        report_fail("golden file has a malformed sprite table line");
                    end else begin
                        for (int j = 0; j < 4; j++) begin
                            vram[e*4 + j] = 8'(b[j]);
                        end
                    end
                end else if (kind == "W" || kind == "P") begin
                    if (kind == "W") begin
                        rc   = $sscanf(line, "W %d %d %d %h %h", f, v, h, a, d);
                        want = 5;
                    end else begin
                        rc   = $sscanf(line, "P %d %d %d %h", f, v, h, d);
                        want = 4;
                        a    = 0;
                    end
                    if (rc != want) begin
                        report_fail("golden file has a malformed write or pixel line");
                    end else begin
                        ev_pos.push_back(f * FRAME + v * H_TOTAL + h);
                        ev_kind.push_back(kind);
                        ev_h.push_back(9'(h));
                        ev_v.push_back(9'(v));
                        ev_addr.push_back(10'(a));
                        ev_data.push_back(8'(d));
                        ev_px.push_back(PXL_W'(d));
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    initial begin
        #(WATCH_CYCLES * 10);
        report_fail("watchdog expired before all golden points were checked");
    end

    initial begin
        logic [8:0] nh;
        logic [8:0] nv;
        load_golden();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        // n counts clocks since reset and hdump should equal n mod H_TOTAL
        for (int i = 0; i < ev_pos.size(); i++) begin
            if (n > ev_pos[i]) begin
                report_fail("golden file events are not in time order");
            end else begin
                while (n < ev_pos[i]) begin
                    @(negedge clk);
                    n++;
                end
                if (ev_kind[i] == "W") begin
                    vram[ev_addr[i]] = ev_data[i];
                end else begin
                    check_timer(ev_h[i], ev_v[i]);
                    // counters one clock later including both wraps
                    nh = (ev_h[i] == 9'(H_TOTAL - 1)) ? 9'd0 : ev_h[i] + 9'd1;
                    nv = ev_v[i];
                    if (ev_h[i] == 9'(H_TOTAL - 1)) begin
                        nv = (ev_v[i] == 9'(V_TOTAL - 1)) ? 9'd0 : ev_v[i] + 9'd1;
                    end
                    @(negedge clk);
                    n++;
                    check_timer(nh, nv);
                    // registered pixel of the listed column
                    check_pxl(ev_px[i]);
                end
            end
        end
        $display("Everything OK");
        $finish;
    end

endmodule

// ==== src/obj_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sprite engine top level
// timer, table DMA, scan, drawer and line buffer
// VRAM and ROM live outside; pxl lags hdump by one
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module obj_top
    import obj_pkg::*;
#(
    parameter int H_TOTAL   = 384,
    parameter int H_VIS     = 256,
    parameter int V_TOTAL   = 264,
    parameter int V_VIS     = 224,
    parameter int OBJ_COUNT = 16
) (
    input  logic             clk,
    input  logic             rst,
    // VRAM, data one clock after address
    output logic [9:0]       vram_addr,
    input  logic [7:0]       vram_data,
    // graphics ROM
    output rom_addr_t        rom_addr,
    output logic             rom_cs,
    input  logic [31:0]      rom_data,
    input  logic             rom_ok,
    // video
    output logic [8:0]       hdump,
    output logic [8:0]       vrender,
    output logic [PXL_W-1:0] pxl
);

    logic                         hs;
    logic                         vbl_start;
    logic [$clog2(OBJ_COUNT)-1:0] rd_addr;
    obj_word_u                    rd_word;
    logic                         draw_req;
    logic                         draw_ack;
    obj_job_t                     job;
    lbuf_wr_t                     lb_wr;

    obj_timer #(
        .H_TOTAL (H_TOTAL),
        .V_TOTAL (V_TOTAL),
        .V_VIS   (V_VIS)
    ) u_timer (
        .clk       (clk),
        .rst       (rst),
        .hdump     (hdump),
        .vrender   (vrender),
        .hs        (hs),
        .vbl_start (vbl_start)
    );

    obj_dma #(
        .OBJ_COUNT (OBJ_COUNT)
    ) u_dma (
        .clk       (clk),
        .rst       (rst),
        .vbl_start (vbl_start),
        .vram_addr (vram_addr),
        .vram_data (vram_data),
        .rd_addr   (rd_addr),
        .rd_word   (rd_word)
    );

    obj_scan_fsm #(
        .V_VIS     (V_VIS),
        .OBJ_COUNT (OBJ_COUNT)
    ) u_scan (
        .clk      (clk),
        .rst      (rst),
        .hs       (hs),
        .vrender  (vrender),
        .rd_addr  (rd_addr),
        .rd_word  (rd_word),
        .draw_req (draw_req),
        .draw_ack (draw_ack),
        .job      (job)
    );

    obj_draw u_draw (
        .clk      (clk),
        .rst      (rst),
        .hs       (hs),
        .draw_req (draw_req),
        .draw_ack (draw_ack),
        .job      (job),
        .rom_addr (rom_addr),
        .rom_cs   (rom_cs),
        .rom_data (rom_data),
        .rom_ok   (rom_ok),
        .lb_wr    (lb_wr)
    );

    obj_line_buf #(
        .H_VIS (H_VIS)
    ) u_lbuf (
        .clk   (clk),
        .rst   (rst),
        .hs    (hs),
        .hdump (hdump),
        .lb_wr (lb_wr),
        .pxl   (pxl)
    );

endmodule

// ==== obj/obj_line_buf.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// double line buffer
// drawer fills one bank while the other plays out
// banks swap at hs; playback clears each entry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module obj_line_buf
    import obj_pkg::*;
#(
    parameter int H_VIS = 256
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             hs,
    input  logic [8:0]       hdump,
    input  lbuf_wr_t         lb_wr,
    output logic [PXL_W-1:0] pxl
);

    localparam int LW = $clog2(H_VIS);

    logic [PXL_W-1:0] mem [2][H_VIS];
    logic             sel;
    logic             rd_bank;

    // new display bank already in the hs cycle
    assign rd_bank = sel ^ hs;

    always_ff @(posedge clk) begin
        if (rst) begin
            sel <= 1'b0;
            pxl <= '0;
        end else begin
            if (hs) begin
                sel <= ~sel;
            end
            if (hdump < 9'(H_VIS)) begin
                pxl <= mem[rd_bank][hdump[LW-1:0]];
            end else begin
                pxl <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        // read and clear
        if (hdump < 9'(H_VIS)) begin
            mem[rd_bank][hdump[LW-1:0]] <= '0;
        end
        // off-screen columns dropped
        if (lb_wr.we && lb_wr.addr < 9'(H_VIS)) begin
            mem[~sel][lb_wr.addr[LW-1:0]] <= lb_wr.color;
        end
    end

endmodule

// ==== obj/obj_draw.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// object drawer
// one queued plus one active job; the active job
// fetches two ROM words per row and writes eight
// pixels per word into the line buffer
// hs flushes everything still pending
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module obj_draw
    import obj_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        hs,
    input  logic        draw_req,
    output logic        draw_ack,
    input  obj_job_t    job,
    output rom_addr_t   rom_addr,
    output logic        rom_cs,
    input  logic [31:0] rom_data,
    input  logic        rom_ok,
    output lbuf_wr_t    lb_wr
);

    typedef enum logic [1:0] {
        D_IDLE,
        D_FETCH,
        D_WRITE
    } dstate_t;

    dstate_t     st;
    obj_job_t    q_job;
    obj_job_t    a_job;
    logic        q_valid;
    logic        half;
    logic [2:0]  px_cnt;
    logic [31:0] px_data;
    logic [2:0]  nib_sel;
    logic [3:0]  nib;
    logic [8:0]  col;

    // hflip fetches the right half first
    assign rom_addr.code = a_job.code;
    assign rom_addr.row  = a_job.row;
    assign rom_addr.half = half ^ a_job.hflip;

    // and walks the nibbles backwards
    assign nib_sel = px_cnt ^ {3{a_job.hflip}};
    assign nib     = px_data[nib_sel*4 +: 4];
    assign col     = a_job.xpos + {5'd0, half, px_cnt};

    always_ff @(posedge clk) begin
        if (rst || hs) begin
            draw_ack <= 1'b0;
            q_valid  <= 1'b0;
            st       <= D_IDLE;
            rom_cs   <= 1'b0;
            half     <= 1'b0;
            px_cnt   <= 3'd0;
            lb_wr.we <= 1'b0;
        end else begin
            // ack only when the queue slot is free
            if (draw_req && !draw_ack && !q_valid) begin
                q_job    <= job;
                q_valid  <= 1'b1;
                draw_ack <= 1'b1;
            end else if (!draw_req && draw_ack) begin
                draw_ack <= 1'b0;
            end

            lb_wr.we <= 1'b0;
            case (st)
                D_IDLE: begin
                    if (q_valid) begin
                        a_job   <= q_job;
                        q_valid <= 1'b0;
                        half    <= 1'b0;
                        rom_cs  <= 1'b1;
                        st      <= D_FETCH;
                    end
                end
                D_FETCH: begin
                    // address held while cs is high
                    if (rom_ok) begin
                        px_data <= rom_data;
                        rom_cs  <= 1'b0;
                        px_cnt  <= 3'd0;
                        st      <= D_WRITE;
                    end
                end
                D_WRITE: begin
                    // colour 0 is transparent
                    lb_wr.we    <= nib != 4'd0;
                    lb_wr.addr  <= col;
                    lb_wr.color <= {a_job.pal, nib};
                    px_cnt      <= px_cnt + 3'd1;
                    if (px_cnt == 3'(HALF_W - 1)) begin
                        if (!half) begin
                            half   <= 1'b1;
                            rom_cs <= 1'b1;
                            st     <= D_FETCH;
                        end else begin
                            st <= D_IDLE;
                        end
                    end
                end
                default: st <= D_IDLE;
            endcase
        end
    end

endmodule

// ==== obj/obj_scan_fsm.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// per line object scan
// walks the attribute table at each hs, tests every
// entry against the next line and hands hits to the
// drawer with a four-phase req/ack handshake
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module obj_scan_fsm
    import obj_pkg::*;
#(
    parameter int V_VIS     = 224,
    parameter int OBJ_COUNT = 16
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         hs,
    input  logic [8:0]                   vrender,
    output logic [$clog2(OBJ_COUNT)-1:0] rd_addr,
    input  obj_word_u                    rd_word,
    output logic                         draw_req,
    input  logic                         draw_ack,
    output obj_job_t                     job
);

    localparam int AW = $clog2(OBJ_COUNT);

    typedef enum logic [2:0] {
        S_IDLE,
        S_READ,
        S_TEST,
        S_REQ,
        S_REL
    } state_t;

    state_t        st;
    obj_attr_t     attr;
    logic [AW-1:0] entry;
    logic [8:0]    target;
    logic [8:0]    ydiff;
    logic          hit;
    logic          last;

    assign rd_addr = entry;
    assign attr    = rd_word.attr;

    // wraps high when ypos is below the target line
    assign ydiff = target - {1'b0, attr.ypos};
    assign hit   = ydiff < 9'(OBJ_W);
    assign last  = entry == AW'(OBJ_COUNT - 1);

    always_ff @(posedge clk) begin
        if (rst) begin
            st       <= S_IDLE;
            entry    <= '0;
            target   <= 9'd0;
            draw_req <= 1'b0;
        end else if (hs) begin
            // unfinished entries of the old line are dropped
            draw_req <= 1'b0;
            entry    <= '0;
            target   <= vrender + 9'd1;
            st       <= vrender < 9'(V_VIS - 1) ? S_READ : S_IDLE;
        end else begin
            case (st)
                // attribute arrives one clock later
                S_READ: st <= S_TEST;
                S_TEST: begin
                    if (!hit) begin
                        entry <= entry + 1'b1;
                        st    <= last ? S_IDLE : S_READ;
                    end else if (!draw_ack) begin
                        // previous handshake fully closed
                        draw_req <= 1'b1;
                        st       <= S_REQ;
                    end
                end
                S_REQ: begin
                    if (draw_ack) begin
                        draw_req <= 1'b0;
                        st       <= S_REL;
                    end
                end
                S_REL: begin
                    if (!draw_ack) begin
                        entry <= entry + 1'b1;
                        st    <= last ? S_IDLE : S_READ;
                    end
                end
                default: st <= S_IDLE;
            endcase
        end
    end

    // frozen while the request is up
    always_ff @(posedge clk) begin
        if (st == S_TEST) begin
            job.code  <= attr.code;
            job.pal   <= attr.pal;
            job.xpos  <= attr.xpos;
            job.hflip <= attr.hflip;
            job.row   <= ydiff[3:0] ^ {4{attr.vflip}};
        end
    end

endmodule

// ==== obj/obj_dma.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// sprite table copy during vertical blank
// reads the VRAM one byte per clock and packs four
// bytes into one attribute word of the write bank
// scan reads the other bank through rd_addr/rd_word
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module obj_dma
    import obj_pkg::*;
#(
    parameter int OBJ_COUNT = 16
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         vbl_start,
    output logic [9:0]                   vram_addr,
    input  logic [7:0]                   vram_data,
    input  logic [$clog2(OBJ_COUNT)-1:0] rd_addr,
    output obj_word_u                    rd_word
);

    localparam int NBYTES = OBJ_COUNT * 4;
    localparam int AW     = $clog2(OBJ_COUNT);

    obj_word_u  mem [2][OBJ_COUNT];
    obj_word_u  asm_word;
    obj_word_u  nxt_word;
    logic       wr_bank;
    logic       rd_bank;
    logic       active;
    logic       dat_valid;
    logic [9:0] byte_cnt;
    logic [9:0] dat_idx;

    assign vram_addr = byte_cnt;

    // scan sees the fresh bank once the copy is over
    assign rd_bank = (active || dat_valid) ? ~wr_bank : wr_bank;

    always_ff @(posedge clk) begin
        if (rst) begin
            active    <= 1'b0;
            dat_valid <= 1'b0;
            wr_bank   <= 1'b0;
            byte_cnt  <= 10'd0;
            dat_idx   <= 10'd0;
        end else begin
            // VRAM answers one clock after the address
            dat_valid <= active;
            dat_idx   <= byte_cnt;
            if (vbl_start) begin
                active   <= 1'b1;
                byte_cnt <= 10'd0;
                wr_bank  <= ~wr_bank;
            end else if (active) begin
                if (byte_cnt == 10'(NBYTES - 1)) begin
                    active <= 1'b0;
                end else begin
                    byte_cnt <= byte_cnt + 10'd1;
                end
            end
        end
    end

    // drop the incoming byte into its lane
    always_comb begin
        nxt_word = asm_word;
        nxt_word.bytes[dat_idx[1:0]] = vram_data;
    end

    always_ff @(posedge clk) begin
        if (dat_valid) begin
            asm_word <= nxt_word;
            // full word after the fourth byte
            if (dat_idx[1:0] == 2'd3) begin
                mem[wr_bank][dat_idx[AW+1:2]] <= nxt_word;
            end
        end
        rd_word <= mem[rd_bank][rd_addr];
    end

endmodule

// ==== src/obj_timer.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// video timing for the sprite engine
// one pixel per clock, hdump and vrender counters
// hs and vbl_start are single cycle strobes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/100ps

module obj_timer #(
    parameter int H_TOTAL = 384,
    parameter int V_TOTAL = 264,
    parameter int V_VIS   = 224
) (
    input  logic       clk,
    input  logic       rst,
    output logic [8:0] hdump,
    output logic [8:0] vrender,
    output logic       hs,
    output logic       vbl_start
);

    always_ff @(posedge clk) begin
        if (rst) begin
            hdump   <= 9'd0;
            vrender <= 9'd0;
        end else if (hdump == 9'(H_TOTAL - 1)) begin
            hdump <= 9'd0;
            // line advances on the horizontal wrap
            if (vrender == 9'(V_TOTAL - 1)) begin
                vrender <= 9'd0;
            end else begin
                vrender <= vrender + 9'd1;
            end
        end else begin
            hdump <= hdump + 9'd1;
        end
    end

    // line start
    assign hs = hdump == 9'd0;

    // first line past the visible area
    assign vbl_start = hs && vrender == 9'(V_VIS);

endmodule

// ==== common/obj_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared types for the sprite engine
// attribute word, draw job, line buffer write and
// ROM address layout, plus the object size constants
// modules take it with a wildcard import
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package obj_pkg;

    // object is square, 16x16 pixels
    localparam int OBJ_W  = 16;
    // one ROM word holds half a row
    localparam int HALF_W = OBJ_W / 2;
    // palette (3) + pixel (4)
    localparam int PXL_W  = 7;

    // one sprite table entry, as seen by scan
    typedef struct packed {
        logic [7:0] ypos;
        logic [8:0] xpos;
        logic       hflip;
        logic       vflip;
        logic [2:0] pal;
        logic [8:0] code;
        logic       spare;
    } obj_attr_t;

    // same 32 bits as raw VRAM bytes, byte 0 in bits 7:0
    typedef union packed {
        obj_attr_t       attr;
        logic [3:0][7:0] bytes;
    } obj_word_u;

    // row is already vertically flipped
    typedef struct packed {
        logic [8:0] code;
        logic [2:0] pal;
        logic [8:0] xpos;
        logic       hflip;
        logic [3:0] row;
    } obj_job_t;

    typedef struct packed {
        logic             we;
        logic [8:0]       addr;
        logic [PXL_W-1:0] color;
    } lbuf_wr_t;

    // word address, half selects left/right 8 pixels
    typedef struct packed {
        logic [8:0] code;
        logic [3:0] row;
        logic       half;
    } rom_addr_t;

endpackage
